/* src/lc3b_types.sv */
package lc3b_types;

	// a 16-bit data and address word.
	typedef logic [15:0] lc3b_word;

	// index of one of the eight general purpose registers.
	typedef logic [2:0] lc3b_reg;

	// LC-3b opcode encodings. Anything not listed decodes as a no-op.
	typedef enum logic [3:0] {
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_not = 4'b1001
	} lc3b_opcode;

	typedef enum logic [1:0] {
		alu_add  = 2'b00,
		alu_and  = 2'b01,
		alu_not  = 2'b10,
		alu_pass = 2'b11
	} lc3b_aluop;

	// an all-zero control word is a no-op in every stage.
	typedef struct packed {
		lc3b_aluop aluop;
		// 0 picks imm5, 1 picks offset6.
		logic      sext_sel;
		logic      imm_sel;
		logic      load_regfile;
		// 0 writes back the ALU result, 1 the load data.
		logic      wb_sel;
		logic      mem_read;
		logic      mem_write;
		logic      pc_sel;
	} lc3b_control_word;

	// instruction fields that follow the control word down the pipe.
	typedef struct packed {
		lc3b_reg  dest;
		lc3b_reg  src_a;
		lc3b_reg  src_b;
		lc3b_word offset;
	} lc3b_passed_vals;

	localparam lc3b_word pc_reset = 16'h0000;

	// instructions are one word, so the PC moves by two bytes.
	localparam lc3b_word pc_step = 16'd2;

	localparam lc3b_word nop_word = 16'h0000;

endpackage : lc3b_types

/* src/control_rom.sv */
`timescale 1ns/1ns

module control_rom (
	input  lc3b_types::lc3b_word         ir,
	output lc3b_types::lc3b_control_word ctrl,
	output lc3b_types::lc3b_passed_vals  passed
);
	import lc3b_types::*;

	lc3b_opcode opcode;
	lc3b_word   sext5;
	lc3b_word   sext6;
	lc3b_word   sext9;

	assign opcode = lc3b_opcode'(ir[15:12]);
	assign sext5  = {{11{ir[4]}}, ir[4:0]};
	assign sext6  = {{10{ir[5]}}, ir[5:0]};
	assign sext9  = {{7{ir[8]}}, ir[8:0]};

	always_comb begin
		ctrl = '0;
		case (opcode)
			op_add: begin
				ctrl.aluop        = alu_add;
				ctrl.imm_sel      = ir[5];
				ctrl.load_regfile = 1'b1;
			end
			op_and: begin
				ctrl.aluop        = alu_and;
				ctrl.imm_sel      = ir[5];
				ctrl.load_regfile = 1'b1;
			end
			op_not: begin
				ctrl.aluop        = alu_not;
				ctrl.load_regfile = 1'b1;
			end
			op_ldr: begin
				ctrl.aluop        = alu_add;
				ctrl.sext_sel     = 1'b1;
				ctrl.imm_sel      = 1'b1;
				ctrl.load_regfile = 1'b1;
				ctrl.wb_sel       = 1'b1;
				ctrl.mem_read     = 1'b1;
			end
			op_str: begin
				ctrl.aluop     = alu_add;
				ctrl.sext_sel  = 1'b1;
				ctrl.imm_sel   = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			// without condition codes any set nzp bit means taken.
			op_br: ctrl.pc_sel = |ir[11:9];
			default: ctrl = '0;
		endcase
	end

	always_comb begin
		passed.dest  = ir[11:9];
		passed.src_a = ir[8:6];
		// a store reads its data register from the dest field.
		passed.src_b = (opcode == op_str) ? ir[11:9] : ir[2:0];
		if (opcode == op_br)
			passed.offset = sext9;
		else if (ctrl.sext_sel)
			passed.offset = sext6;
		else
			passed.offset = sext5;
	end

endmodule : control_rom

/* src/regfile.sv */
`timescale 1ns/1ns

module regfile (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 load,
	input  lc3b_types::lc3b_reg  dest,
	input  lc3b_types::lc3b_word in,
	input  lc3b_types::lc3b_reg  src_a,
	input  lc3b_types::lc3b_reg  src_b,
	output lc3b_types::lc3b_word reg_a,
	output lc3b_types::lc3b_word reg_b
);
	import lc3b_types::*;

	lc3b_word regs [8];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (load) begin
			regs[dest] <= in;
		end
	end

	// a write in flight is visible to decode in the same cycle.
	assign reg_a = (load && dest == src_a) ? in : regs[src_a];
	assign reg_b = (load && dest == src_b) ? in : regs[src_b];

	a_wb_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		load |-> !$isunknown(in)
	) else $error("regfile: writeback value is unknown for r%0d", dest);

endmodule : regfile

/* src/alu.sv */
`timescale 1ns/1ns

module alu (
	input  lc3b_types::lc3b_aluop aluop,
	input  lc3b_types::lc3b_word  a,
	input  lc3b_types::lc3b_word  b,
	output lc3b_types::lc3b_word  f
);
	import lc3b_types::*;

	always_comb begin
		case (aluop)
			alu_add:  f = a + b;
			alu_and:  f = a & b;
			alu_not:  f = ~a;
			alu_pass: f = b;
			default:  f = b;
		endcase
	end

	// the ALU has no clock, so the opcode is checked whenever it changes.
	always_comb begin
		a_aluop_known: assert (!$isunknown(aluop))
			else $error("alu: aluop is unknown");
	end

endmodule : alu

/* src/datapath.sv */
`timescale 1ns/1ns

module datapath (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 stall,
	input  logic                 mem_resp_0,
	input  logic                 mem_resp_1,
	input  lc3b_types::lc3b_word mem_rdata_0,
	input  lc3b_types::lc3b_word mem_rdata_1,
	output lc3b_types::lc3b_word mem_address_0,
	output lc3b_types::lc3b_word mem_address_1,
	output lc3b_types::lc3b_word mem_wdata_1,
	output logic                 mem_read_0,
	output logic                 mem_read_1,
	output logic                 mem_write_1
);
	import lc3b_types::*;

	lc3b_word pc, pc_plus2, pc_next;
	lc3b_word ir, ir_in, fetch_buf, if_pc;
	logic     fetch_held, data_held;

	lc3b_control_word gen_ctrl, id_ctrl, ex_ctrl, mem_ctrl;
	lc3b_passed_vals  gen_passed, id_passed, ex_passed, mem_passed;

	lc3b_word reg_a, reg_b;
	lc3b_word id_pc, sr1, sr2;
	lc3b_word imm_val, alu_b, alu_f, br_target;
	lc3b_word ex_alu, ex_wdata, ex_pc;
	lc3b_word load_buf, load_in, mem_data, mem_alu, wb_val;

	// fetch. A response that lands while the pipe is frozen is parked in
	// fetch_buf and the request drops until the pipe moves again.
	assign mem_address_0 = pc;
	assign mem_read_0    = ~fetch_held;
	assign pc_plus2      = pc + pc_step;
	assign pc_next       = ex_ctrl.pc_sel ? ex_pc : pc_plus2;
	assign ir_in         = fetch_held ? fetch_buf : mem_rdata_0;

	// decode.
	control_rom u_ctrl (
		.ir     (ir),
		.ctrl   (gen_ctrl),
		.passed (gen_passed)
	);

	regfile u_regs (
		.clk   (clk),
		.rst_n (rst_n),
		.load  (mem_ctrl.load_regfile & ~stall),
		.dest  (mem_passed.dest),
		.in    (wb_val),
		.src_a (gen_passed.src_a),
		.src_b (gen_passed.src_b),
		.reg_a (reg_a),
		.reg_b (reg_b)
	);

	// execute. Memory offsets are word offsets and get scaled to bytes here.
	assign imm_val   = id_ctrl.sext_sel ? {id_passed.offset[14:0], 1'b0} : id_passed.offset;
	assign alu_b     = id_ctrl.imm_sel ? imm_val : sr2;
	assign br_target = id_pc + {id_passed.offset[14:0], 1'b0};

	alu u_alu (
		.aluop (id_ctrl.aluop),
		.a     (sr1),
		.b     (alu_b),
		.f     (alu_f)
	);

	// memory. The data port request also drops once its response is parked.
	assign mem_address_1 = ex_alu;
	assign mem_wdata_1   = ex_wdata;
	assign mem_read_1    = ex_ctrl.mem_read & ~data_held;
	assign mem_write_1   = ex_ctrl.mem_write & ~data_held;
	assign load_in       = data_held ? load_buf : mem_rdata_1;

	// writeback.
	assign wb_val = mem_ctrl.wb_sel ? mem_data : mem_alu;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc         <= pc_reset;
			ir         <= nop_word;
			fetch_held <= 1'b0;
			data_held  <= 1'b0;
			id_ctrl    <= '0;
			ex_ctrl    <= '0;
			mem_ctrl   <= '0;
		end else if (!stall) begin
			pc         <= pc_next;
			ir         <= ir_in;
			fetch_held <= 1'b0;
			data_held  <= 1'b0;
			id_ctrl    <= gen_ctrl;
			ex_ctrl    <= id_ctrl;
			mem_ctrl   <= ex_ctrl;
		end else begin
			if (mem_resp_0)
				fetch_held <= 1'b1;
			if (mem_resp_1)
				data_held <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (stall && mem_resp_0)
			fetch_buf <= mem_rdata_0;
		if (stall && mem_resp_1)
			load_buf <= mem_rdata_1;
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			if_pc      <= pc_plus2;
			id_passed  <= gen_passed;
			id_pc      <= if_pc;
			sr1        <= reg_a;
			sr2        <= reg_b;
			ex_passed  <= id_passed;
			ex_alu     <= alu_f;
			ex_wdata   <= sr2;
			ex_pc      <= br_target;
			mem_passed <= ex_passed;
			mem_alu    <= ex_alu;
			mem_data   <= load_in;
		end
	end

	a_rw_exclusive: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(mem_read_1 && mem_write_1)
	) else $error("datapath: mem_read_1 and mem_write_1 both high at %h", mem_address_1);

endmodule : datapath

/* src/stall_unit.sv */
`timescale 1ns/1ns

module stall_unit (
	input  logic clk,
	input  logic rst_n,
	input  logic mem_read_0,
	input  logic mem_read_1,
	input  logic mem_write_1,
	input  logic mem_resp_0,
	input  logic mem_resp_1,
	output logic stall
);

	logic seen_0, seen_1;
	logic busy_0, busy_1;

	// a port is busy until it answers, and stays satisfied for the rest of
	// the stall once it has.
	assign busy_0 = mem_read_0 & ~mem_resp_0 & ~seen_0;
	assign busy_1 = (mem_read_1 | mem_write_1) & ~mem_resp_1 & ~seen_1;
	assign stall  = busy_0 | busy_1;

	always_ff @(posedge clk) begin
		if (!rst_n || !stall) begin
			seen_0 <= 1'b0;
			seen_1 <= 1'b0;
		end else begin
			if (mem_resp_0)
				seen_0 <= 1'b1;
			if (mem_resp_1)
				seen_1 <= 1'b1;
		end
	end

	a_resp_needs_req: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(mem_resp_0 && !mem_read_0) && !(mem_resp_1 && !(mem_read_1 || mem_write_1))
	) else $error("stall_unit: response without a request level");

endmodule : stall_unit

/* src/lc3b_cpu.sv */
`timescale 1ns/1ns

module lc3b_cpu (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 mem_resp_0,
	input  lc3b_types::lc3b_word mem_rdata_0,
	output lc3b_types::lc3b_word mem_address_0,
	output logic                 mem_read_0,
	input  logic                 mem_resp_1,
	input  lc3b_types::lc3b_word mem_rdata_1,
	output lc3b_types::lc3b_word mem_address_1,
	output lc3b_types::lc3b_word mem_wdata_1,
	output logic                 mem_read_1,
	output logic                 mem_write_1
);

	logic stall;

	datapath u_datapath (
		.clk           (clk),
		.rst_n         (rst_n),
		.stall         (stall),
		.mem_resp_0    (mem_resp_0),
		.mem_resp_1    (mem_resp_1),
		.mem_rdata_0   (mem_rdata_0),
		.mem_rdata_1   (mem_rdata_1),
		.mem_address_0 (mem_address_0),
		.mem_address_1 (mem_address_1),
		.mem_wdata_1   (mem_wdata_1),
		.mem_read_0    (mem_read_0),
		.mem_read_1    (mem_read_1),
		.mem_write_1   (mem_write_1)
	);

	stall_unit u_stall (
		.clk         (clk),
		.rst_n       (rst_n),
		.mem_read_0  (mem_read_0),
		.mem_read_1  (mem_read_1),
		.mem_write_1 (mem_write_1),
		.mem_resp_0  (mem_resp_0),
		.mem_resp_1  (mem_resp_1),
		.stall       (stall)
	);

endmodule : lc3b_cpu

/* tb/mem_model.sv */
`timescale 1ns/1ns

module mem_model (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 random_lat,
	input  lc3b_types::lc3b_word addr0,
	input  logic                 read0,
	output logic                 resp0,
	output lc3b_types::lc3b_word rdata0,
	input  lc3b_types::lc3b_word addr1,
	input  lc3b_types::lc3b_word wdata1,
	input  logic                 read1,
	input  logic                 write1,
	output logic                 resp1,
	output lc3b_types::lc3b_word rdata1
);
	import lc3b_types::*;

	// word addressed, so byte address bit 0 is dropped.
	lc3b_word imem [512];
	lc3b_word dmem [512];
	int       wait0;
	int       wait1;

	function automatic int pick_delay();
		int d;
		d = 0;
		if (random_lat)
			d = int'($urandom_range(3, 0));
		return d;
	endfunction

	initial begin
		resp0  = 1'b0;
		resp1  = 1'b0;
		rdata0 = '0;
		rdata1 = '0;
		wait0  = 0;
		wait1  = 0;
	end

	// responses change on the falling edge so the DUT samples them cleanly.
	always @(negedge clk) begin
		if (!rst_n) begin
			resp0 <= 1'b0;
			wait0 <= pick_delay();
		end else if (read0 && wait0 == 0) begin
			resp0  <= 1'b1;
			rdata0 <= imem[addr0[9:1]];
			wait0  <= pick_delay();
		end else begin
			resp0 <= 1'b0;
			if (read0)
				wait0 <= wait0 - 1;
		end
	end

	always @(negedge clk) begin
		if (!rst_n) begin
			resp1 <= 1'b0;
			wait1 <= pick_delay();
		end else if ((read1 || write1) && wait1 == 0) begin
			resp1 <= 1'b1;
			if (write1)
				dmem[addr1[9:1]] <= wdata1;
			else
				rdata1 <= dmem[addr1[9:1]];
			wait1 <= pick_delay();
		end else begin
			resp1 <= 1'b0;
			if (read1 || write1)
				wait1 <= wait1 - 1;
		end
	end

endmodule : mem_model

/* tb/tb_lc3b.sv */
`timescale 1ns/1ns

module tb_lc3b;
	import lc3b_types::*;

	logic     clk, rst_n, random_lat;
	logic     mem_resp_0, mem_read_0, mem_resp_1, mem_read_1, mem_write_1;
	lc3b_word mem_rdata_0, mem_address_0, mem_rdata_1, mem_address_1, mem_wdata_1;

	lc3b_word prog [256];
	lc3b_word preload [512];
	lc3b_word smem [512];
	lc3b_word sregs [8];
	lc3b_word exp_addr [$];
	lc3b_word exp_data [$];
	int       prog_len;
	int       store_idx;

	lc3b_cpu DUT (.*);

	mem_model u_mem (
		.clk(clk), .rst_n(rst_n), .random_lat(random_lat),
		.addr0(mem_address_0), .read0(mem_read_0), .resp0(mem_resp_0),
		.rdata0(mem_rdata_0), .addr1(mem_address_1), .wdata1(mem_wdata_1),
		.read1(mem_read_1), .write1(mem_write_1), .resp1(mem_resp_1),
		.rdata1(mem_rdata_1)
	);

	always #4 clk = ~clk;

	task automatic fail_value(string name, lc3b_word expected, lc3b_word actual);
		$display("FAIL %s expected %h got %h", name, expected, actual);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic fail_words(string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	function automatic lc3b_word enc_reg(lc3b_opcode op, lc3b_reg d, lc3b_reg a, lc3b_reg b);
		return {op, d, a, 3'b000, b};
	endfunction

	function automatic lc3b_word enc_imm(lc3b_opcode op, lc3b_reg d, lc3b_reg a,
			logic [4:0] imm);
		return {op, d, a, 1'b1, imm};
	endfunction

	function automatic lc3b_word enc_mem(lc3b_opcode op, lc3b_reg r, lc3b_reg base,
			logic [5:0] off);
		return {op, r, base, off};
	endfunction

	function automatic lc3b_word enc_br(logic [2:0] nzp, logic [8:0] off);
		return {op_br, nzp, off};
	endfunction

	// every real instruction is followed by four no-ops.
	task automatic emit(lc3b_word w);
		prog[prog_len] = w;
		prog_len += 5;
	endtask

	task automatic build_program();
		int br_idx;
		prog_len = 0;
		foreach (prog[i])
			prog[i] = nop_word;
		emit(enc_mem(op_ldr, 3'd1, 3'd0, 6'd16));
		emit(enc_mem(op_ldr, 3'd2, 3'd0, 6'd17));
		emit(enc_mem(op_ldr, 3'd6, 3'd0, 6'd19));
		emit(enc_reg(op_add, 3'd3, 3'd1, 3'd2));
		emit(enc_mem(op_str, 3'd3, 3'd0, 6'd0));
		emit(enc_reg(op_and, 3'd4, 3'd1, 3'd2));
		emit(enc_mem(op_str, 3'd4, 3'd0, 6'd1));
		emit({op_not, 3'd5, 3'd1, 6'b111111});
		emit(enc_mem(op_str, 3'd5, 3'd0, 6'd2));
		for (int i = 0; i < 4; i++) begin
			emit(enc_imm(op_add, 3'd3, 3'd1, 5'($urandom)));
			emit(enc_mem(op_str, 3'd3, 3'd6, 6'($urandom)));
			emit(enc_imm(op_and, 3'd4, 3'd2, 5'($urandom)));
			emit(enc_mem(op_str, 3'd4, 3'd6, 6'($urandom)));
		end
		emit(enc_mem(op_ldr, 3'd7, 3'd0, 6'd18));
		emit(enc_imm(op_add, 3'd7, 3'd7, 5'd1));
		emit(enc_mem(op_str, 3'd7, 3'd0, 6'd3));
		// a BR with nzp clear falls through to its store.
		emit(enc_br(3'b000, 9'd5));
		emit(enc_imm(op_add, 3'd3, 3'd0, 5'd7));
		emit(enc_mem(op_str, 3'd3, 3'd0, 6'd4));
		br_idx = prog_len;
		emit(nop_word);
		emit(enc_imm(op_add, 3'd3, 3'd0, 5'd11));
		emit(enc_mem(op_str, 3'd3, 3'd0, 6'd5));
		emit(enc_mem(op_str, 3'd3, 3'd0, 6'd6));
		prog[br_idx] = enc_br(3'b111, 9'(prog_len - br_idx - 1));
		emit(enc_imm(op_add, 3'd3, 3'd0, 5'd13));
		emit(enc_mem(op_str, 3'd3, 3'd0, 6'd7));
		// branch to itself to park the core.
		emit(enc_br(3'b111, 9'h1ff));
	endtask

	task automatic run_shadow();
		lc3b_word pc, w, opnd, addr, target;
		lc3b_reg  d, a;
		bit       halted;
		int       steps;
		pc = pc_reset;
		halted = 0;
		steps = 0;
		foreach (sregs[i])
			sregs[i] = '0;
		foreach (smem[i])
			smem[i] = preload[i];
		while (!halted && steps < 4000) begin
			w = prog[pc[8:1]];
			d = w[11:9];
			a = w[8:6];
			opnd = w[5] ? {{11{w[4]}}, w[4:0]} : sregs[w[2:0]];
			addr = sregs[a] + {{9{w[5]}}, w[5:0], 1'b0};
			case (lc3b_opcode'(w[15:12]))
				op_add: sregs[d] = sregs[a] + opnd;
				op_and: sregs[d] = sregs[a] & opnd;
				op_not: sregs[d] = ~sregs[a];
				op_ldr: sregs[d] = smem[addr[9:1]];
				op_str: begin
					smem[addr[9:1]] = sregs[d];
					exp_addr.push_back(addr);
					exp_data.push_back(sregs[d]);
				end
				op_br: begin
					target = pc + pc_step + {{6{w[8]}}, w[8:0], 1'b0};
					if (w[11:9] != 3'b000 && target == pc)
						halted = 1;
					else if (w[11:9] != 3'b000)
						pc = target - pc_step;
				end
				default: ;
			endcase
			pc = pc + pc_step;
			steps++;
		end
	endtask

	task automatic reset_and_load(bit lat);
		@(negedge clk);
		rst_n <= 1'b0;
		random_lat <= lat;
		foreach (u_mem.imem[i])
			u_mem.imem[i] = (i < 256) ? prog[i] : nop_word;
		foreach (u_mem.dmem[i])
			u_mem.dmem[i] = preload[i];
		repeat (4) @(negedge clk);
		rst_n <= 1'b1;
	endtask

	task automatic wait_for_stores();
		int idle, prev;
		idle = 0;
		while (store_idx < exp_addr.size()) begin
			prev = store_idx;
			@(posedge clk);
			idle = (store_idx == prev) ? idle + 1 : 0;
			if (idle > 300)
				fail_words($sformatf("store %0d of %0d never appeared",
					store_idx + 1, exp_addr.size()));
		end
		// let the parked core run to catch any extra store.
		repeat (60) @(posedge clk);
	endtask

	// store-order checker against the shadow model.
	always @(posedge clk) begin
		if (!rst_n) begin
			store_idx <= 0;
		end else if (mem_write_1 && mem_resp_1) begin
			if (store_idx >= exp_addr.size())
				fail_words("a store appeared after the last expected one");
			a_store_addr: assert (mem_address_1 == exp_addr[store_idx])
				else fail_value("mem_address_1", exp_addr[store_idx], mem_address_1);
			a_store_data: assert (mem_wdata_1 == exp_data[store_idx])
				else fail_value("mem_wdata_1", exp_data[store_idx], mem_wdata_1);
			store_idx <= store_idx + 1;
		end
	end

	a_fetch_stall: assert property (@(posedge clk) disable iff (!rst_n)
		(mem_read_0 && !mem_resp_0) |-> DUT.stall)
		else fail_words("stall was low while a fetch was still pending");

	a_data_stall: assert property (@(posedge clk) disable iff (!rst_n)
		((mem_read_1 || mem_write_1) && !mem_resp_1) |-> DUT.stall)
		else fail_words("stall was low while a data access was still pending");

	a_fetch_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(mem_read_0 && !mem_resp_0) |=> $stable(mem_address_0))
		else fail_words("mem_address_0 changed while its fetch was waiting");

	a_reset_idle: assert property (@(posedge clk)
		!rst_n |=> (!mem_read_1 && !mem_write_1 && mem_read_0))
		else fail_words("memory request levels were wrong right after reset");

	initial begin
		void'($urandom(17589));
		clk = 1'b1;
		rst_n = 1'b0;
		random_lat = 1'b0;
		foreach (preload[i])
			preload[i] = lc3b_word'(i * 257) ^ 16'h3c5a;
		preload[16] = lc3b_word'($urandom);
		preload[17] = lc3b_word'($urandom);
		preload[18] = lc3b_word'($urandom);
		preload[19] = 16'h0100;
		build_program();
		run_shadow();
		reset_and_load(1'b0);
		wait_for_stores();
		// same program again with random response latency on both ports.
		reset_and_load(1'b1);
		wait_for_stores();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule : tb_lc3b

/* lc3b_pipe.f */
src/lc3b_types.sv
src/control_rom.sv
src/regfile.sv
src/alu.sv
src/datapath.sv
src/stall_unit.sv
src/lc3b_cpu.sv
tb/mem_model.sv
tb/tb_lc3b.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_lc3b
FILELIST  ?= lc3b_pipe.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
